// File: source/img_preproc_pkg.sv
// Shared types for the raw image path; coordinates are 12 bits, so images are at most 4095 per side

package img_preproc_pkg;

    // Stream word width on the host side
    localparam int WORD_W = 32;

    // Pixel coordinate width, also the packed x and y field width
    localparam int COORD_W = 12;

    // Integer luma weights, they sum to 256 so the shift by 8 cannot overflow
    localparam int LUMA_R_WEIGHT = 77;
    localparam int LUMA_G_WEIGHT = 150;
    localparam int LUMA_B_WEIGHT = 29;

    // One host word, least significant byte first
    typedef logic [WORD_W-1:0] word_t;

    // Bytes left in the current image
    typedef logic [31:0] byte_count_t;

    // One bit per valid byte, always contiguous from bit 0
    typedef logic [3:0] strobe_t;

    typedef logic [COORD_W-1:0] coord_t;

    // Colour channel or luma value
    typedef logic [7:0] channel_t;

    // Decoder phases
    typedef enum logic [1:0] {
        HEADER,
        PIXELS,
        DRAIN
    } decode_state_t;

    // Framer to decoder word
    typedef struct packed {
        word_t   data;
        strobe_t strobe;
        logic    last;
    } payload_word_t;

    // Decoder to luma stage pixel
    typedef struct packed {
        channel_t r;
        channel_t g;
        channel_t b;
        coord_t   x;
        coord_t   y;
        logic     last;
    } rgb_pixel_t;

endpackage

// File: source/stream_framer.sv
// Length word must lead each image; a zero length word while idle only pulses abort, no timeout
`timescale 1ns/1ps

module stream_framer
    import img_preproc_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  word_t         in_data_i,
    input  logic          in_valid_i,
    input  logic          payload_accept_i,
    output logic          payload_valid_o,
    output payload_word_t payload_o,
    output logic          abort_o,
    output logic          upstream_stall_o
);

    // Remaining payload bytes, zero means idle and waiting for a length word
    byte_count_t byte_count;
    logic        idle;
    logic        transfer;

    assign idle = (byte_count == '0);
    assign transfer = payload_valid_o && payload_accept_i;

    always_ff @(posedge clock) begin
        if (reset) begin
            byte_count <= '0;
        end else if (idle && in_valid_i) begin
            // Length word, a zero value leaves the framer idle
            byte_count <= in_data_i;
        end else if (transfer) begin
            // Full word or whatever is left of the image
            byte_count <= (byte_count >= 4) ? byte_count - 4 : '0;
        end
    end

    // Payload only flows between length word and end of image
    assign payload_valid_o = in_valid_i && !idle;
    assign payload_o.data = in_data_i;

    always_comb begin
        // All bytes valid unless the tail is shorter than a word
        payload_o.strobe = 4'b1111;
        case (byte_count)
            1: payload_o.strobe = 4'b0001;
            2: payload_o.strobe = 4'b0011;
            3: payload_o.strobe = 4'b0111;
            default: payload_o.strobe = 4'b1111;
        endcase
    end

    // Final word of the image
    assign payload_o.last = (byte_count <= 4);

    // Zero length word seen while idle
    assign abort_o = in_valid_i && idle && (in_data_i == '0);

    // Length word is always taken, payload waits on the decoder
    assign upstream_stall_o = idle ? 1'b0 : !payload_accept_i;

    // Host holds a refused word until it is taken
    assert property (@(posedge clock) disable iff (reset)
        in_valid_i && upstream_stall_o |=> in_valid_i && $stable(in_data_i));

endmodule

// File: source/raw_image_decoder.sv
// Raw RGB payload only, 4-byte size header first; malformed headers are not flagged, just drained
`timescale 1ns/1ps

module raw_image_decoder
    import img_preproc_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          payload_valid_i,
    input  payload_word_t payload_i,
    input  logic          abort_i,
    input  logic          pixel_ready_i,
    output logic          payload_accept_o,
    output logic          pixel_valid_o,
    output rgb_pixel_t    pixel_o
);

    // Word buffer, bytes leave from the bottom
    word_t         buf_data;
    strobe_t       buf_strobe;
    logic          buf_last;

    decode_state_t state;
    // Header byte index, or channel index while in pixels
    logic [1:0]    byte_idx;

    coord_t        width_q;
    coord_t        height_q;
    coord_t        x_q;
    coord_t        y_q;
    channel_t      red_q;
    channel_t      green_q;

    rgb_pixel_t    pixel_q;
    logic          pixel_valid_q;

    channel_t      cur_byte;
    coord_t        height_next;
    logic          pixel_hold;
    logic          consume;
    logic          end_of_stream;
    logic          pixel_fire;
    logic          row_end;
    logic          frame_end;

    // New word only into an empty buffer
    assign payload_accept_o = (buf_strobe == '0);

    // Registered pixel still waiting blocks byte flow
    assign pixel_hold = pixel_valid_q && !pixel_ready_i;
    assign consume = buf_strobe[0] && !pixel_hold;
    assign cur_byte = buf_data[7:0];

    // Final byte of the framer's last word
    assign end_of_stream = consume && buf_last && (buf_strobe[3:1] == '0);

    // Height as it will be once the last header byte lands
    assign height_next = {cur_byte[COORD_W-9:0], height_q[7:0]};

    assign pixel_fire = consume && (state == PIXELS) && (byte_idx == 2'd2);
    assign row_end = (x_q == width_q - coord_t'(1));
    assign frame_end = row_end && (y_q == height_q - coord_t'(1));

    always_ff @(posedge clock) begin
        if (reset || abort_i) begin
            buf_strobe <= '0;
        end else if (payload_valid_i && payload_accept_o) begin
            buf_strobe <= payload_i.strobe;
        end else if (consume) begin
            buf_strobe <= buf_strobe >> 1;
        end
    end

    always_ff @(posedge clock) begin
        if (payload_valid_i && payload_accept_o) begin
            buf_data <= payload_i.data;
            buf_last <= payload_i.last;
        end else if (consume) begin
            buf_data <= buf_data >> 8;
        end
    end

    // State, byte index and coordinates
    always_ff @(posedge clock) begin
        if (reset || abort_i) begin
            state <= HEADER;
            byte_idx <= '0;
        end else if (consume) begin
            byte_idx <= byte_idx + 2'd1;
            case (state)
                HEADER: begin
                    if (byte_idx == 2'd3) begin
                        byte_idx <= '0;
                        x_q <= '0;
                        y_q <= '0;
                        // Empty image has nothing to decode
                        state <= (width_q == '0 || height_next == '0) ? DRAIN : PIXELS;
                    end
                end
                PIXELS: begin
                    if (byte_idx == 2'd2) begin
                        byte_idx <= '0;
                        x_q <= row_end ? '0 : x_q + coord_t'(1);
                        if (row_end) begin
                            y_q <= y_q + coord_t'(1);
                        end
                        if (frame_end) begin
                            state <= DRAIN;
                        end
                    end
                end
                default: begin
                    // Padding, discarded
                    byte_idx <= '0;
                end
            endcase
            // End of payload always restarts on a new header
            if (end_of_stream) begin
                state <= HEADER;
                byte_idx <= '0;
            end
        end
    end

    // Header fields and colour bytes
    always_ff @(posedge clock) begin
        if (consume && state == HEADER) begin
            case (byte_idx)
                2'd0: width_q[7:0] <= cur_byte;
                2'd1: width_q[COORD_W-1:8] <= cur_byte[COORD_W-9:0];
                2'd2: height_q[7:0] <= cur_byte;
                default: height_q[COORD_W-1:8] <= cur_byte[COORD_W-9:0];
            endcase
        end
        if (consume && state == PIXELS && byte_idx == 2'd0) begin
            red_q <= cur_byte;
        end
        if (consume && state == PIXELS && byte_idx == 2'd1) begin
            green_q <= cur_byte;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pixel_valid_q <= 1'b0;
        end else if (pixel_fire) begin
            pixel_valid_q <= 1'b1;
        end else if (pixel_ready_i) begin
            pixel_valid_q <= 1'b0;
        end
    end

    // Pixel captured with the blue byte
    always_ff @(posedge clock) begin
        if (pixel_fire) begin
            pixel_q <= '{r: red_q, g: green_q, b: cur_byte, x: x_q, y: y_q, last: frame_end};
        end
    end

    assign pixel_valid_o = pixel_valid_q;
    assign pixel_o = pixel_q;

    // Held pixel stays put until the luma stage takes it
    assert property (@(posedge clock) disable iff (reset)
        pixel_valid_o && !pixel_ready_i |=> pixel_valid_o && $stable(pixel_o));

    // Coordinates inside the parsed frame
    assert property (@(posedge clock) disable iff (reset)
        state == PIXELS |-> x_q < width_q && y_q < height_q);

endmodule

// File: source/luma_stage.sv
// Integer luma, weights 77/150/29 with a shift by 8; downstream stall freezes both registers
`timescale 1ns/1ps

module luma_stage
    import img_preproc_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       pixel_valid_i,
    input  rgb_pixel_t pixel_i,
    input  logic       downstream_stall_i,
    output logic       pixel_ready_o,
    output word_t      out_data_o,
    output logic       out_valid_o,
    output logic       out_last_o
);

    // First register, weighted products
    logic        s1_valid;
    logic [15:0] s1_r_prod;
    logic [15:0] s1_g_prod;
    logic [15:0] s1_b_prod;
    coord_t      s1_x;
    coord_t      s1_y;
    logic        s1_last;

    // Second register, packed result
    logic        s2_valid;
    word_t       s2_data;
    logic        s2_last;

    // Weights sum to 256, so the sum fits 16 bits
    logic [15:0] luma_sum;
    channel_t    luma;

    // First register is free, or drains this cycle
    assign pixel_ready_o = !downstream_stall_i || !s1_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else if (pixel_ready_o) begin
            s1_valid <= pixel_valid_i;
        end
    end

    always_ff @(posedge clock) begin
        if (pixel_ready_o && pixel_valid_i) begin
            s1_r_prod <= 16'(LUMA_R_WEIGHT * pixel_i.r);
            s1_g_prod <= 16'(LUMA_G_WEIGHT * pixel_i.g);
            s1_b_prod <= 16'(LUMA_B_WEIGHT * pixel_i.b);
            s1_x <= pixel_i.x;
            s1_y <= pixel_i.y;
            s1_last <= pixel_i.last;
        end
    end

    assign luma_sum = s1_r_prod + s1_g_prod + s1_b_prod;
    assign luma = luma_sum[15:8];

    always_ff @(posedge clock) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else if (!downstream_stall_i) begin
            s2_valid <= s1_valid;
        end
    end

    // Luma on top, then x, then y
    always_ff @(posedge clock) begin
        if (!downstream_stall_i && s1_valid) begin
            s2_data <= {luma, s1_x, s1_y};
            s2_last <= s1_last;
        end
    end

    assign out_valid_o = s2_valid;
    assign out_data_o = s2_data;
    assign out_last_o = s2_valid && s2_last;

    // Stalled result is held unchanged
    assert property (@(posedge clock) disable iff (reset)
        out_valid_o && downstream_stall_i |=> out_valid_o && $stable(out_data_o));

endmodule

// File: source/img_preproc_top.sv
// Raw RGB stand-in for the JPEG core; output word is luma, x, y and has no debug fields
`timescale 1ns/1ps

module img_preproc_top
    import img_preproc_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  word_t in_data_i,
    input  logic  in_valid_i,
    input  logic  downstream_stall_i,
    output word_t out_data_o,
    output logic  out_valid_o,
    output logic  out_last_o,
    output logic  upstream_stall_o
);

    // Framer to decoder
    logic          payload_valid;
    logic          payload_accept;
    payload_word_t payload;
    logic          abort;

    // Decoder to luma stage
    logic          pixel_valid;
    logic          pixel_ready;
    rgb_pixel_t    pixel;

    stream_framer framer_i (
        .clock            (clock),
        .reset            (reset),
        .in_data_i        (in_data_i),
        .in_valid_i       (in_valid_i),
        .payload_accept_i (payload_accept),
        .payload_valid_o  (payload_valid),
        .payload_o        (payload),
        .abort_o          (abort),
        .upstream_stall_o (upstream_stall_o)
    );

    raw_image_decoder decoder_i (
        .clock            (clock),
        .reset            (reset),
        .payload_valid_i  (payload_valid),
        .payload_i        (payload),
        .abort_i          (abort),
        .pixel_ready_i    (pixel_ready),
        .payload_accept_o (payload_accept),
        .pixel_valid_o    (pixel_valid),
        .pixel_o          (pixel)
    );

    luma_stage luma_i (
        .clock              (clock),
        .reset              (reset),
        .pixel_valid_i      (pixel_valid),
        .pixel_i            (pixel),
        .downstream_stall_i (downstream_stall_i),
        .pixel_ready_o      (pixel_ready),
        .out_data_o         (out_data_o),
        .out_valid_o        (out_valid_o),
        .out_last_o         (out_last_o)
    );

endmodule

// File: verification/img_preproc_tb.sv
// Images of at most 8 by 8 pixels from a fixed LFSR seed; a zero length word is only sent between images
`timescale 1ns/1ps

module img_preproc_tb
    import img_preproc_pkg::*;
();

    localparam int IMAGES_PER_TEST = 4;
    // Four tests of four images, then the empty image and one normal image
    localparam int TOTAL_IMAGES = 4 * IMAGES_PER_TEST + 2;
    // Header, 8x8 RGB triples and the widest padding
    localparam int MAX_IMAGE_BYTES = 4 + 3 * 64 + 12;
    localparam int WATCHDOG_CYCLES = TOTAL_IMAGES * MAX_IMAGE_BYTES * 40 + 2000;

    logic  clock;
    logic  reset;
    word_t in_data_i;
    logic  in_valid_i;
    logic  downstream_stall_i;
    word_t out_data_o;
    logic  out_valid_o;
    logic  out_last_o;
    logic  upstream_stall_o;

    logic [31:0] lfsr_state = 32'he2e5_7db6;
    // Expected output words, last flag in bit 32
    logic [32:0] expected_q[$];
    logic        stall_on;
    logic        gaps_on;
    int          check_count = 0;
    int          error_count = 0;
    int          output_count = 0;
    // Counter snapshots at the start of each test
    int          outputs_before = 0;
    int          errors_before = 0;

    img_preproc_top dut_i (
        .clock              (clock),
        .reset              (reset),
        .in_data_i          (in_data_i),
        .in_valid_i         (in_valid_i),
        .downstream_stall_i (downstream_stall_i),
        .out_data_o         (out_data_o),
        .out_valid_o        (out_valid_o),
        .out_last_o         (out_last_o),
        .upstream_stall_o   (upstream_stall_o)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #10 clock = ~clock;
        end
    end

    // One Galois step, returns the bit shifted out
    function automatic logic random_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out_bit;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value = {value[30:0], random_bit()};
        end
        return value;
    endfunction

    // Weighted sum of the channels, top 8 bits kept
    function automatic channel_t expected_luma(input channel_t r, input channel_t g,
                                               input channel_t b);
        int sum;
        sum = LUMA_R_WEIGHT * r + LUMA_G_WEIGHT * g + LUMA_B_WEIGHT * b;
        return channel_t'(sum >> 8);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, want, $time);
        end
    endtask

    // Word is taken on the rising edge after the stall is seen low
    task automatic send_word(input word_t word, input logic length_word);
        @(negedge clock);
        while (gaps_on && random_bits(2) == 0) begin
            in_valid_i = 1'b0;
            @(negedge clock);
        end
        in_data_i = word;
        in_valid_i = 1'b1;
        // A length word is never refused
        if (length_word) begin
            check_value("upstream_stall_o", 32'(upstream_stall_o), 32'd0);
        end
        while (upstream_stall_o) begin
            @(negedge clock);
        end
    endtask

    task automatic release_input();
        @(negedge clock);
        in_valid_i = 1'b0;
    endtask

    // Length word, header, RGB triples and padding, packed low byte first
    task automatic send_image(input int width, input int height, input int pad);
        logic [7:0] image_bytes[$];
        channel_t   r;
        channel_t   g;
        channel_t   b;
        word_t      word;
        logic       last;
        int         x;
        int         y;
        int         i;
        int         k;
        image_bytes.push_back(8'(width));
        image_bytes.push_back(8'(width >> 8));
        image_bytes.push_back(8'(height));
        image_bytes.push_back(8'(height >> 8));
        for (y = 0; y < height; y++) begin
            for (x = 0; x < width; x++) begin
                r = channel_t'(random_bits(8));
                g = channel_t'(random_bits(8));
                b = channel_t'(random_bits(8));
                image_bytes.push_back(r);
                image_bytes.push_back(g);
                image_bytes.push_back(b);
                last = (x == width - 1) && (y == height - 1);
                expected_q.push_back({last, expected_luma(r, g, b), coord_t'(x), coord_t'(y)});
            end
        end
        for (i = 0; i < pad; i++) begin
            image_bytes.push_back(8'(random_bits(8)));
        end
        send_word(word_t'(image_bytes.size()), 1'b1);
        for (i = 0; i < image_bytes.size(); i += 4) begin
            word = '0;
            for (k = 0; k < 4; k++) begin
                // Bytes past the end are junk the strobe has to mask
                word[8*k +: 8] = (i + k < image_bytes.size()) ? image_bytes[i + k]
                                                              : 8'(random_bits(8));
            end
            send_word(word, 1'b0);
        end
    endtask

    // Pad mode 0 word aligned, 1 always a partial last word, else 0 to 3 bytes
    task automatic run_images(input int count, input int pad_mode);
        int n;
        int width;
        int height;
        int pixel_bytes;
        int pad;
        for (n = 0; n < count; n++) begin
            width = 1 + int'(random_bits(3));
            height = 1 + int'(random_bits(3));
            pixel_bytes = 4 + 3 * width * height;
            case (pad_mode)
                0: pad = (4 - pixel_bytes % 4) % 4;
                1: begin
                    pad = 1 + int'(random_bits(3));
                    if ((pixel_bytes + pad) % 4 == 0) begin
                        pad = pad + 1;
                    end
                end
                default: pad = int'(random_bits(2));
            endcase
            send_image(width, height, pad);
        end
        release_input();
    endtask

    // Done once every expected word has come out
    task automatic finish_test(input int number, input string name);
        while (expected_q.size() != 0) begin
            @(negedge clock);
        end
        $display("Test %0d %s: %0d words checked, %0d errors", number, name,
                 output_count - outputs_before, error_count - errors_before);
        outputs_before = output_count;
        errors_before = error_count;
    endtask

    // Downstream stall driver and output monitor
    initial begin : output_monitor
        logic [32:0] expected;
        logic        next_stall;
        logic        held_valid;
        word_t       held_data;
        downstream_stall_i = 1'b0;
        next_stall = 1'b0;
        held_valid = 1'b0;
        held_data = '0;
        forever begin
            // Stall bits drawn on the rising edge, stimulus bits on the falling edge
            @(posedge clock);
            next_stall = stall_on && (random_bits(2) == 0);
            @(negedge clock);
            downstream_stall_i = next_stall;
            if (!reset) begin
                if (held_valid) begin
                    check_value("out_valid_o while stalled", 32'(out_valid_o), 32'd1);
                    check_value("out_data_o while stalled", out_data_o, held_data);
                end
                held_valid = out_valid_o && downstream_stall_i;
                held_data = out_data_o;
                if (out_valid_o && !downstream_stall_i) begin
                    if (expected_q.size() == 0) begin
                        error_count++;
                        $display("Output word %h arrived with no pixel expected", out_data_o);
                    end else begin
                        expected = expected_q.pop_front();
                        check_value("out_data_o", out_data_o, expected[31:0]);
                        check_value("out_last_o", 32'(out_last_o), 32'(expected[32]));
                        output_count++;
                    end
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Run timed out after %0d cycles with %0d output words still missing",
                 WATCHDOG_CYCLES, expected_q.size());
        $display("Errors found");
        $finish;
    end

    initial begin
        reset = 1'b1;
        in_valid_i = 1'b0;
        in_data_i = '0;
        stall_on = 1'b0;
        gaps_on = 1'b0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        run_images(IMAGES_PER_TEST, 0);
        finish_test(1, "pixel stream");
        run_images(IMAGES_PER_TEST, 1);
        finish_test(2, "partial final word");
        stall_on = 1'b1;
        run_images(IMAGES_PER_TEST, 2);
        finish_test(3, "back-pressure");
        gaps_on = 1'b1;
        run_images(IMAGES_PER_TEST, 2);
        finish_test(4, "input pacing");
        stall_on = 1'b0;
        gaps_on = 1'b0;
        // Abort, then a zero width image, then a normal one
        send_word('0, 1'b1);
        send_image(0, 3, 4);
        send_image(1 + int'(random_bits(3)), 1 + int'(random_bits(3)), 2);
        release_input();
        finish_test(5, "abort and empty image");
        // Quiet period catches words that should never appear
        repeat (50) @(negedge clock);
        $display("%0d checks, %0d words, %0d errors", check_count, output_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: img_preproc_top.f
source/img_preproc_pkg.sv
source/stream_framer.sv
source/raw_image_decoder.sv
source/luma_stage.sv
source/img_preproc_top.sv
verification/img_preproc_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= img_preproc_tb
RTL_TOP    ?= img_preproc_top
FILE_LIST  ?= img_preproc_top.f
BUILD_DIR  ?= build
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only
PASS_TEXT  ?= No errors
RTL_SOURCES = source/img_preproc_pkg.sv source/stream_framer.sv \
              source/raw_image_decoder.sv source/luma_stage.sv \
              source/img_preproc_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SOURCES)

clean:
	rm -rf $(BUILD_DIR)
